/* Makefile */
# Verilator lint and simulation for the pce_io project

VERILATOR ?= verilator
FILELIST  ?= pce_io.f
TB_TOP    ?= pce_io_tb
RTL_TOP   ?= pce_io_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only if the pass message appears on a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* audio/audio_mixer.sv */
// PSG, CD-DA and ADPCM sum with saturation to offset-binary DAC words
`timescale 1ns/1ps
`include "pce_io_params.svh"

module audio_mixer (
	input  logic                           clk_sys,
	input  logic                           rst,
	input  logic signed [`PCE_SRC_W-1:0]   psg_l,
	input  logic signed [`PCE_SRC_W-1:0]   psg_r,
	input  logic signed [`PCE_SRC_W-1:0]   cdda_l,
	input  logic signed [`PCE_SRC_W-1:0]   cdda_r,
	input  logic signed [`PCE_ADPCM_W-1:0] adpcm,
	output logic        [`PCE_DAC_W-1:0]   audio_l,
	output logic        [`PCE_DAC_W-1:0]   audio_r
);

	localparam int MW = `PCE_MIX_W;
	localparam int DW = `PCE_DAC_W;

	logic signed [MW-1:0] adpcm_ext;
	logic signed [MW-1:0] sum_l;
	logic signed [MW-1:0] sum_r;

	// Clamp to DW-bit signed, then flip the sign bit for offset binary
	function automatic logic [DW-1:0] sat_offset(input logic signed [MW-1:0] v);
		logic in_range;
		in_range = (v[MW-1:DW-1] == '0) || (v[MW-1:DW-1] == '1);
		if (in_range)
			sat_offset = {~v[DW-1], v[DW-2:0]};
		else
			sat_offset = {DW{~v[MW-1]}};   // All ones high, all zeros low
	endfunction

	assign adpcm_ext = {{(MW - `PCE_ADPCM_W - 4){adpcm[`PCE_ADPCM_W-1]}}, adpcm, 4'b0000};

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= MW'(psg_l) + MW'(cdda_l) + adpcm_ext;
			sum_r <= MW'(psg_r) + MW'(cdda_r) + adpcm_ext;
		end
	end

	assign audio_l = sat_offset(sum_l);
	assign audio_r = sat_offset(sum_r);

endmodule

/* common/pce_io_params.svh */
// Widths and counts for the pad scanner, mouse timeout and audio mixer
`ifndef PCE_IO_PARAMS_SVH
`define PCE_IO_PARAMS_SVH

// ========================================
// Controller port
// ========================================

`define PCE_NUM_PADS    5   // Pads behind the Turbo Tap
`define PCE_PAD_BITS    12  // Buttons and directions per pad

// Clear-low cycles before the mouse phase resyncs
`define PCE_MS_TO_BITS  15

// ========================================
// Audio
// ========================================

`define PCE_SRC_W       20  // PSG and CD-DA samples
`define PCE_ADPCM_W     16  // ADPCM sample, scaled by 16 in the mix
`define PCE_MIX_W       22  // Headroom for the three-source sum
`define PCE_DAC_W       19  // Offset-binary word to the sigma-delta DAC

`endif

/* common/pce_io_pkg.sv */
// Shared types for the controller port logic

package pce_io_pkg;

	// Mouse byte is read as four nibbles, one per clear pulse
	typedef enum logic [1:0] {
		MS_X_HI = 2'd0,
		MS_X_LO = 2'd1,
		MS_Y_HI = 2'd2,
		MS_Y_LO = 2'd3
	} ms_nib_e;

	// Turbo Tap port, 0..4 are pads and above is the idle word
	typedef logic [2:0] port_idx_t;

	// Active-low nibble returned to the core
	typedef logic [3:0] nibble_t;

	// Four nibbles of one port, indexed by {bank, select}
	typedef logic [15:0] pad_word_t;

endpackage

/* dv/pce_io_tb.sv */
// Testbench for the controller port and audio glue
// Table-driven audio, pad, Turbo Tap, six-button and mouse checks
`timescale 1ns/1ps
`include "pce_io_params.svh"

module pce_io_tb;

	localparam int N_AUD = 24;
	localparam int N_FIX = 6;      // Hand-picked audio rows ahead of the random ones
	localparam int N_PAD = 17;
	// Bounds of 1 cycle per audio row, 36 per pad row and 16 per mouse phase, doubled
	localparam int CYCLE_LIMIT = 2 * (10 + N_AUD + 36 * N_PAD + 16 * 4) + 100;

	typedef struct packed {
		logic       swap;
		logic       tap;
		logic       b6;
		logic [3:0] n_sel;       // Select pulses after the clear
		logic       sel;         // Final select level
		logic [2:0] port;        // Expected port
		logic       bank;        // Expected high bank
	} pad_row_t;

	logic clk_sys, rst, pad_sel, pad_clr, mouse_strobe;
	logic joy_swap, turbotap, buttons6, mouse_en;
	logic [`PCE_PAD_BITS-1:0] joy_v [`PCE_NUM_PADS];
	logic [7:0] mouse_dx, mouse_dy;
	logic [1:0] mouse_btn;
	logic signed [`PCE_SRC_W-1:0] psg_l, psg_r, cdda_l, cdda_r;
	logic signed [`PCE_ADPCM_W-1:0] adpcm;
	pce_io_pkg::nibble_t pad_nibble;
	logic [`PCE_DAC_W-1:0] audio_l, audio_r;

	// ========================================
	// Stimulus and expected tables
	// ========================================

	logic signed [`PCE_SRC_W-1:0]   t_psg_l [N_AUD];
	logic signed [`PCE_SRC_W-1:0]   t_psg_r [N_AUD];
	logic signed [`PCE_SRC_W-1:0]   t_cd_l [N_AUD];
	logic signed [`PCE_SRC_W-1:0]   t_cd_r [N_AUD];
	logic signed [`PCE_ADPCM_W-1:0] t_adp [N_AUD];
	logic [`PCE_DAC_W-1:0]          t_exp_l [N_AUD];
	logic [`PCE_DAC_W-1:0]          t_exp_r [N_AUD];
	logic [3:0]                     ms_exp [4];

	pad_row_t pad_tab [N_PAD] = '{
		'{1'b0, 1'b0, 1'b0, 4'd0, 1'b0, 3'd0, 1'b0},   // Plain read of pad 0
		'{1'b0, 1'b0, 1'b0, 4'd0, 1'b1, 3'd0, 1'b0},
		'{1'b1, 1'b0, 1'b0, 4'd0, 1'b0, 3'd0, 1'b0},   // Swap shows pad 1
		'{1'b1, 1'b0, 1'b0, 4'd0, 1'b1, 3'd0, 1'b0},
		'{1'b0, 1'b0, 1'b1, 4'd0, 1'b0, 3'd0, 1'b1},   // Six-button banks
		'{1'b0, 1'b0, 1'b1, 4'd0, 1'b0, 3'd0, 1'b0},
		'{1'b0, 1'b0, 1'b1, 4'd0, 1'b1, 3'd0, 1'b1},
		'{1'b0, 1'b0, 1'b1, 4'd0, 1'b1, 3'd0, 1'b0},
		'{1'b0, 1'b1, 1'b0, 4'd1, 1'b0, 3'd1, 1'b0},   // Turbo Tap stepping
		'{1'b0, 1'b1, 1'b0, 4'd2, 1'b1, 3'd2, 1'b0},
		'{1'b0, 1'b1, 1'b0, 4'd3, 1'b0, 3'd3, 1'b0},
		'{1'b0, 1'b1, 1'b0, 4'd4, 1'b1, 3'd4, 1'b0},
		'{1'b0, 1'b1, 1'b0, 4'd5, 1'b0, 3'd5, 1'b0},
		'{1'b0, 1'b1, 1'b0, 4'd6, 1'b1, 3'd6, 1'b0},
		'{1'b1, 1'b1, 1'b0, 4'd1, 1'b1, 3'd1, 1'b0},
		'{1'b0, 1'b0, 1'b0, 4'd3, 1'b0, 3'd0, 1'b0},   // Port stays 0 with the tap off
		'{1'b0, 1'b0, 1'b0, 4'd5, 1'b1, 3'd0, 1'b0}
	};

	int          checks = 0;
	int          errors = 0;
	int          cycles = 0;
	logic [31:0] lfsr = 32'hbfc7b55f;

	pce_io_top i_dut (
		.clk_sys (clk_sys), .rst (rst), .pad_sel (pad_sel), .pad_clr (pad_clr),
		.pad_nibble (pad_nibble),
		.joy_0 (joy_v[0]), .joy_1 (joy_v[1]), .joy_2 (joy_v[2]),
		.joy_3 (joy_v[3]), .joy_4 (joy_v[4]),
		.mouse_dx (mouse_dx), .mouse_dy (mouse_dy), .mouse_btn (mouse_btn),
		.mouse_strobe (mouse_strobe), .joy_swap (joy_swap), .turbotap (turbotap),
		.buttons6 (buttons6), .mouse_en (mouse_en),
		.psg_l (psg_l), .psg_r (psg_r), .cdda_l (cdda_l), .cdda_r (cdda_r),
		.adpcm (adpcm), .audio_l (audio_l), .audio_r (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per returned bit
	function automatic logic [31:0] rand_bits(input int n);
		int          k;
		logic [31:0] v;
		v = '0;
		for (k = 0; k < n; k++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		rand_bits = v;
	endfunction

	// Sum, clamp to the signed DAC range, then shift to offset binary
	function automatic logic [`PCE_DAC_W-1:0] mix_expect(
		input logic signed [`PCE_SRC_W-1:0] p, input logic signed [`PCE_SRC_W-1:0] c,
		input logic signed [`PCE_ADPCM_W-1:0] a);
		int v;
		int lim;
		int res;
		lim = 1 << (`PCE_DAC_W - 1);
		v = int'(p) + int'(c) + 16 * int'(a);
		if (v > lim - 1)
			v = lim - 1;
		else if (v < -lim)
			v = -lim;
		res = v + lim;
		mix_expect = res[`PCE_DAC_W-1:0];
	endfunction

	// Active-low nibble of a port word picked by bank and select
	function automatic pce_io_pkg::nibble_t expect_pad(input logic [2:0] port,
		input logic bank, input logic sel, input logic swap);
		logic [`PCE_PAD_BITS-1:0] b;
		logic [2:0]               pad;
		pad = (swap && port < 3'd2) ? 3'd1 - port : port;
		if (port >= 3'd5) begin
			expect_pad = ({bank, sel} == 2'b11) ? 4'h0 : 4'hF;   // Empty tap slot
		end else begin
			b = joy_v[pad];
			case ({bank, sel})
				2'b00:   expect_pad = ~b[7:4];
				2'b01:   expect_pad = ~{b[1], b[2], b[0], b[3]};
				2'b10:   expect_pad = ~b[11:8];
				default: expect_pad = 4'h0;
			endcase
		end
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic check_nibble(input pce_io_pkg::nibble_t exp, input string what);
		checks++;
		if (pad_nibble !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s nibble got %h expected %h",
				$time, what, pad_nibble, exp);
		end
	endtask

	task automatic check_audio(input logic [`PCE_DAC_W-1:0] el,
		input logic [`PCE_DAC_W-1:0] er, input string what);
		checks += 2;
		if (audio_l !== el) begin
			errors++;
			$display("MISMATCH at %0t: %s left got %h expected %h", $time, what, audio_l, el);
		end
		if (audio_r !== er) begin
			errors++;
			$display("MISMATCH at %0t: %s right got %h expected %h", $time, what, audio_r, er);
		end
	endtask

	task automatic set_aud_row(input int i,
		input logic signed [`PCE_SRC_W-1:0] pl, input logic signed [`PCE_SRC_W-1:0] pr,
		input logic signed [`PCE_SRC_W-1:0] cl, input logic signed [`PCE_SRC_W-1:0] cr,
		input logic signed [`PCE_ADPCM_W-1:0] ad);
		t_psg_l[i] = pl;
		t_psg_r[i] = pr;
		t_cd_l[i]  = cl;
		t_cd_r[i]  = cr;
		t_adp[i]   = ad;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		wait_cycles(4);
		rst = 1'b0;
		check_nibble(4'h0, "reset");
		wait_cycles(1);
		check_audio(19'h40000, 19'h40000, "reset");   // Offset value for zero
	endtask

	// Select high first so no select edge lands inside the clear
	task automatic pulse_clear();
		pad_sel = 1'b1;
		wait_cycles(2);
		pad_clr = 1'b1;
		wait_cycles(2);
		check_nibble(4'h0, "clear");
		pad_clr = 1'b0;
	endtask

	task automatic run_pad_row(input int idx);
		pad_row_t row;
		row = pad_tab[idx];
		joy_swap = row.swap;
		turbotap = row.tap;
		buttons6 = row.b6;
		pulse_clear();
		repeat (row.n_sel) begin
			pad_sel = 1'b0;
			wait_cycles(2);
			pad_sel = 1'b1;
			wait_cycles(2);
		end
		pad_sel = row.sel;
		wait_cycles(4);
		check_nibble(expect_pad(row.port, row.bank, row.sel, row.swap),
			$sformatf("pad row %0d", idx));
	endtask

	initial begin
		int          i;
		logic [31:0] r;
		logic [7:0]  nx;

		rst = 1'b1;
		{pad_sel, pad_clr, mouse_strobe} = '0;
		{joy_swap, turbotap, buttons6, mouse_en} = '0;
		{mouse_dx, mouse_dy, mouse_btn} = '0;
		{psg_l, psg_r, cdda_l, cdda_r, adpcm} = '0;
		for (i = 0; i < `PCE_NUM_PADS; i++) begin
			r = rand_bits(`PCE_PAD_BITS);
			joy_v[i] = r[`PCE_PAD_BITS-1:0];
		end

		// Zero, both saturation ends, exact limits, one past them
		set_aud_row(0, 20'sd0, 20'sd0, 20'sd0, 20'sd0, 16'sd0);
		set_aud_row(1, 20'sh7ffff, 20'sh80000, 20'sh7ffff, 20'sh80000, 16'sh7fff);
		set_aud_row(2, 20'sd262143, -20'sd262144, 20'sd0, 20'sd0, 16'sd0);
		set_aud_row(3, 20'sd262144, -20'sd262145, 20'sd0, 20'sd0, 16'sd0);
		set_aud_row(4, -20'sd100, 20'sd16, 20'sd100, 20'sd0, 16'sd16383);
		set_aud_row(5, 20'sd0, 20'sh7ffff, 20'sd0, 20'sd0, 16'sh8000);
		for (i = N_FIX; i < N_AUD; i++) begin
			r = rand_bits(20);
			t_psg_l[i] = r[19:0];
			r = rand_bits(20);
			t_psg_r[i] = r[19:0];
			r = rand_bits(20);
			t_cd_l[i] = r[19:0];
			r = rand_bits(20);
			t_cd_r[i] = r[19:0];
			r = rand_bits(16);
			t_adp[i] = r[15:0];
			if (i % 2 == 1) begin   // Smaller samples to land inside the clamp
				t_psg_l[i] = t_psg_l[i] >>> 2;
				t_psg_r[i] = t_psg_r[i] >>> 2;
				t_cd_l[i]  = t_cd_l[i] >>> 2;
				t_cd_r[i]  = t_cd_r[i] >>> 2;
				t_adp[i]   = t_adp[i] >>> 3;
			end
		end
		for (i = 0; i < N_AUD; i++) begin
			t_exp_l[i] = mix_expect(t_psg_l[i], t_cd_l[i], t_adp[i]);
			t_exp_r[i] = mix_expect(t_psg_r[i], t_cd_r[i], t_adp[i]);
		end

		@(negedge clk_sys);
		apply_reset();

		// ========================================
		// Audio rows one cycle apart
		// ========================================
		for (i = 0; i < N_AUD; i++) begin
			psg_l  = t_psg_l[i];
			psg_r  = t_psg_r[i];
			cdda_l = t_cd_l[i];
			cdda_r = t_cd_r[i];
			adpcm  = t_adp[i];
			wait_cycles(1);
			check_audio(t_exp_l[i], t_exp_r[i], $sformatf("audio row %0d", i));
		end
		{psg_l, psg_r, cdda_l, cdda_r, adpcm} = '0;

		for (i = 0; i < N_PAD; i++)
			run_pad_row(i);

		// ========================================
		// Mouse reads from phase Y_LO after reset
		// ========================================
		{joy_swap, turbotap, buttons6} = '0;
		apply_reset();
		mouse_en = 1'b1;
		r = rand_bits(18);
		mouse_dx  = r[7:0];
		mouse_dy  = r[15:8];
		mouse_btn = r[17:16];
		mouse_strobe = 1'b1;
		wait_cycles(1);
		mouse_strobe = 1'b0;
		nx = 8'd0 - mouse_dx;   // X axis reads reversed
		ms_exp[0] = nx[7:4];
		ms_exp[1] = nx[3:0];
		ms_exp[2] = mouse_dy[7:4];
		ms_exp[3] = mouse_dy[3:0];
		for (i = 0; i < 4; i++) begin
			pulse_clear();      // First one also commits
			wait_cycles(4);
			check_nibble(ms_exp[i], $sformatf("mouse phase %0d", i));
			pad_sel = 1'b0;
			wait_cycles(4);
			check_nibble(~{joy_v[0][7:6], mouse_btn[0], mouse_btn[1]},
				$sformatf("mouse buttons %0d", i));
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* hdl/pce_io_top.sv */
// Controller and audio glue around the console core
`timescale 1ns/1ps
`include "pce_io_params.svh"

module pce_io_top (
	input  logic                             clk_sys,
	input  logic                             rst,
	input  logic                             pad_sel,      // joy_out[0]
	input  logic                             pad_clr,      // joy_out[1]
	output pce_io_pkg::nibble_t              pad_nibble,
	input  logic        [`PCE_PAD_BITS-1:0]  joy_0,
	input  logic        [`PCE_PAD_BITS-1:0]  joy_1,
	input  logic        [`PCE_PAD_BITS-1:0]  joy_2,
	input  logic        [`PCE_PAD_BITS-1:0]  joy_3,
	input  logic        [`PCE_PAD_BITS-1:0]  joy_4,
	input  logic        [7:0]                mouse_dx,
	input  logic        [7:0]                mouse_dy,
	input  logic        [1:0]                mouse_btn,    // [0] left, [1] right
	input  logic                             mouse_strobe,
	input  logic                             joy_swap,
	input  logic                             turbotap,
	input  logic                             buttons6,
	input  logic                             mouse_en,
	input  logic signed [`PCE_SRC_W-1:0]     psg_l,
	input  logic signed [`PCE_SRC_W-1:0]     psg_r,
	input  logic signed [`PCE_SRC_W-1:0]     cdda_l,
	input  logic signed [`PCE_SRC_W-1:0]     cdda_r,
	input  logic signed [`PCE_ADPCM_W-1:0]   adpcm,
	output logic        [`PCE_DAC_W-1:0]     audio_l,
	output logic        [`PCE_DAC_W-1:0]     audio_r
);

	pce_io_pkg::port_idx_t port_idx;
	logic                  high_bank;
	logic                  sel_bit;
	logic                  latch_clear;
	pce_io_pkg::ms_nib_e   ms_phase;
	logic                  ms_commit;
	logic [7:0]            ms_x;
	logic [7:0]            ms_y;

	// ========================================
	// Pad scanning
	// ========================================

	pad_scan_ctrl #(
		.TO_BITS (`PCE_MS_TO_BITS)
	) i_scan (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.pad_sel     (pad_sel),
		.pad_clr     (pad_clr),
		.turbotap    (turbotap),
		.buttons6    (buttons6),
		.port_idx    (port_idx),
		.high_bank   (high_bank),
		.sel_bit     (sel_bit),
		.latch_clear (latch_clear),
		.ms_phase    (ms_phase),
		.ms_commit   (ms_commit)
	);

	pad_data_mux i_mux (
		.clk_sys     (clk_sys),
		.rst         (rst),
		.joy_0       (joy_0),
		.joy_1       (joy_1),
		.joy_2       (joy_2),
		.joy_3       (joy_3),
		.joy_4       (joy_4),
		.mouse_btn   (mouse_btn),
		.joy_swap    (joy_swap),
		.mouse_en    (mouse_en),
		.port_idx    (port_idx),
		.high_bank   (high_bank),
		.sel_bit     (sel_bit),
		.latch_clear (latch_clear),
		.ms_phase    (ms_phase),
		.ms_x        (ms_x),
		.ms_y        (ms_y),
		.pad_nibble  (pad_nibble)
	);

	mouse_accum i_mouse (
		.clk_sys      (clk_sys),
		.rst          (rst),
		.mouse_dx     (mouse_dx),
		.mouse_dy     (mouse_dy),
		.mouse_strobe (mouse_strobe),
		.ms_commit    (ms_commit),
		.ms_x         (ms_x),
		.ms_y         (ms_y)
	);

	// ========================================
	// Audio
	// ========================================

	audio_mixer i_audio (
		.clk_sys (clk_sys),
		.rst     (rst),
		.psg_l   (psg_l),
		.psg_r   (psg_r),
		.cdda_l  (cdda_l),
		.cdda_r  (cdda_r),
		.adpcm   (adpcm),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

/* pad/mouse_accum.sv */
// Pending mouse deltas, published once per four-nibble read cycle
`timescale 1ns/1ps

module mouse_accum (
	input  logic       clk_sys,
	input  logic       rst,
	input  logic [7:0] mouse_dx,
	input  logic [7:0] mouse_dy,
	input  logic       mouse_strobe,
	input  logic       ms_commit,
	output logic [7:0] ms_x,
	output logic [7:0] ms_y
);

	logic [7:0] pend_x;
	logic [7:0] pend_y;

	// Strobe after commit so a same-cycle sample is kept pending
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pend_x <= '0;
			pend_y <= '0;
			ms_x   <= '0;
			ms_y   <= '0;
		end else begin
			if (ms_commit) begin
				ms_x   <= pend_x;
				ms_y   <= pend_y;
				pend_x <= '0;
				pend_y <= '0;
			end

			if (mouse_strobe) begin
				pend_x <= 8'd0 - mouse_dx;     // Console X axis is reversed
				pend_y <= mouse_dy;
			end
		end
	end

endmodule

/* pad/pad_data_mux.sv */
// Pad swap, button remap, port and nibble select, registered output nibble
`timescale 1ns/1ps
`include "pce_io_params.svh"

module pad_data_mux (
	input  logic                         clk_sys,
	input  logic                         rst,
	input  logic [`PCE_PAD_BITS-1:0]     joy_0,
	input  logic [`PCE_PAD_BITS-1:0]     joy_1,
	input  logic [`PCE_PAD_BITS-1:0]     joy_2,
	input  logic [`PCE_PAD_BITS-1:0]     joy_3,
	input  logic [`PCE_PAD_BITS-1:0]     joy_4,
	input  logic [1:0]                   mouse_btn,
	input  logic                         joy_swap,
	input  logic                         mouse_en,
	input  pce_io_pkg::port_idx_t        port_idx,
	input  logic                         high_bank,
	input  logic                         sel_bit,
	input  logic                         latch_clear,
	input  pce_io_pkg::ms_nib_e          ms_phase,
	input  logic [7:0]                   ms_x,
	input  logic [7:0]                   ms_y,
	output pce_io_pkg::nibble_t          pad_nibble
);

	logic [`PCE_PAD_BITS-1:0] pad_btn [`PCE_NUM_PADS];
	pce_io_pkg::nibble_t      ms_nib;
	logic [7:0]               mouse_byte;
	pce_io_pkg::pad_word_t    port_word;

	// Active-low word from the top as zero, 11..8, directions and 7..4
	function automatic pce_io_pkg::pad_word_t remap(input logic [`PCE_PAD_BITS-1:0] b);
		remap = ~{4'hF, b[11:8], b[1], b[2], b[0], b[3], b[7:4]};
	endfunction

	assign pad_btn[0] = joy_swap ? joy_1 : joy_0;
	assign pad_btn[1] = joy_swap ? joy_0 : joy_1;
	assign pad_btn[2] = joy_2;
	assign pad_btn[3] = joy_3;
	assign pad_btn[4] = joy_4;

	// ========================================
	// Mouse byte on port 0
	// ========================================

	always_comb begin
		case (ms_phase)
			pce_io_pkg::MS_X_HI: ms_nib = ms_x[7:4];
			pce_io_pkg::MS_X_LO: ms_nib = ms_x[3:0];
			pce_io_pkg::MS_Y_HI: ms_nib = ms_y[7:4];
			default:             ms_nib = ms_y[3:0];
		endcase
	end

	assign mouse_byte = {ms_nib, ~{pad_btn[0][7:6], mouse_btn[0], mouse_btn[1]}};

	always_comb begin
		if (port_idx >= 3'(`PCE_NUM_PADS)) begin
			port_word = 16'h0FFF;              // Empty tap slot
		end else if (port_idx == 3'd0 && mouse_en) begin
			port_word = {mouse_byte, mouse_byte};
		end else begin
			port_word = remap(pad_btn[port_idx]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pad_nibble <= '0;
		end else if (latch_clear) begin
			pad_nibble <= '0;
		end else begin
			pad_nibble <= port_word[{high_bank, sel_bit, 2'b00} +: 4];
		end
	end

endmodule

/* pad/pad_scan_ctrl.sv */
// Select/clear edge detection, Turbo Tap port counter, six-button bank
// and mouse nibble phase with resync timeout
`timescale 1ns/1ps
`include "pce_io_params.svh"

module pad_scan_ctrl #(
	parameter int TO_BITS = `PCE_MS_TO_BITS
) (
	input  logic                  clk_sys,
	input  logic                  rst,
	input  logic                  pad_sel,
	input  logic                  pad_clr,
	input  logic                  turbotap,
	input  logic                  buttons6,
	output pce_io_pkg::port_idx_t port_idx,
	output logic                  high_bank,
	output logic                  sel_bit,
	output logic                  latch_clear,
	output pce_io_pkg::ms_nib_e   ms_phase,
	output logic                  ms_commit
);

	logic               sel_d;
	logic               clr_d;
	logic               sel_rise;
	logic               clr_rise;
	logic [TO_BITS-1:0] to_cnt;
	logic               to_full;

	assign sel_rise = pad_sel & ~sel_d;
	assign clr_rise = pad_clr & ~clr_d;
	assign to_full  = &to_cnt;

	// Nibble choice and clear follow the lines directly
	assign sel_bit     = pad_sel;
	assign latch_clear = pad_clr;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			sel_d <= 1'b0;
			clr_d <= 1'b0;
		end else begin
			sel_d <= pad_sel;
			clr_d <= pad_clr;
		end
	end

	// ========================================
	// Port counter and button bank
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			port_idx  <= '0;
			high_bank <= 1'b0;
		end else begin
			if (clr_rise) begin
				port_idx <= '0;
			end else if (sel_rise && !pad_clr && turbotap) begin
				port_idx <= port_idx + 3'd1;   // Next pad on the tap
			end

			if (!buttons6) begin
				high_bank <= 1'b0;
			end else if (clr_rise) begin
				high_bank <= ~high_bank;       // Banks alternate per clear
			end
		end
	end

	// ========================================
	// Mouse nibble phase
	// ========================================

	// Long idle on clear means the host restarted its read
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			to_cnt <= '0;
		end else if (pad_clr) begin
			to_cnt <= '0;
		end else if (!to_full) begin
			to_cnt <= to_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ms_phase  <= pce_io_pkg::MS_Y_LO;
			ms_commit <= 1'b0;
		end else begin
			ms_commit <= 1'b0;
			if (clr_rise) begin
				ms_phase <= pce_io_pkg::ms_nib_e'(ms_phase + 2'd1);
				if (ms_phase == pce_io_pkg::MS_Y_LO)
					ms_commit <= 1'b1;         // New sample for the next read cycle
			end else if (to_full) begin
				ms_phase <= pce_io_pkg::MS_Y_LO;
			end
		end
	end

endmodule

/* pce_io.f */
+incdir+common
common/pce_io_pkg.sv
pad/pad_scan_ctrl.sv
pad/pad_data_mux.sv
pad/mouse_accum.sv
audio/audio_mixer.sv
hdl/pce_io_top.sv
dv/pce_io_tb.sv
